// ==== Bender.yml ====
package:
  name: feature_window

sources:
  - source/feature_pkg.sv
  - source/pixel_stream_if.sv
  - source/feature_mem.sv
  - source/scan_counter.sv
  - source/read_sequencer.sv
  - source/line_buffer.sv
  - source/window_builder.sv
  - source/feature_window_ctrl.sv
  - target: test
    files:
      - testbench/feature_window_checker.sv
      - testbench/feature_window_props.sv
      - testbench/tb_feature_window.sv

// ==== project.f ====
source/feature_pkg.sv
source/pixel_stream_if.sv
source/feature_mem.sv
source/scan_counter.sv
source/read_sequencer.sv
source/line_buffer.sv
source/window_builder.sv
source/feature_window_ctrl.sv
testbench/feature_window_checker.sv
testbench/feature_window_props.sv
testbench/tb_feature_window.sv

// ==== source/feature_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module feature_mem
    import feature_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              wb_cyc,
    input  wire              wb_stb,
    input  wire              wb_we,
    input  wire addr_t       wb_adr,
    input  wire pixel_t      wb_dat_w,
    output pixel_t           wb_dat_r,
    output logic             wb_ack,
    pixel_stream_if.mem_side stream
);

    pixel_t mem [MEM_DEPTH];
    logic   wb_req;

    // new request, not yet acked
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_ack       <= 1'b0;
            stream.valid <= 1'b0;
        end
        else
        begin
            wb_ack       <= wb_req;
            stream.valid <= stream.rd_en;
        end
    end

    ////////////////////////////////////////
    // port a, wishbone
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (wb_req)
        begin
            if (wb_we)
                mem[wb_adr] <= wb_dat_w;
            wb_dat_r <= mem[wb_adr];    // returned with ack
        end
    end

    ////////////////////////////////////////
    // port b, scan stream
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (stream.rd_en)
            stream.pixel <= mem[stream.rd_addr];
    end

endmodule

`default_nettype wire

// ==== source/feature_pkg.sv ====
`default_nettype none

package feature_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int FEATURE_WIDTH = 8;
    localparam int TN            = 2;   // parallel input channels
    localparam int KERNEL_SIZE   = 3;
    localparam int ADDR_WIDTH    = 8;
    localparam int MEM_DEPTH     = 1 << ADDR_WIDTH;
    localparam int WINDOW_TAPS   = KERNEL_SIZE * KERNEL_SIZE;

    ////////////////////////////////////////
    // data types
    ////////////////////////////////////////
    typedef logic [FEATURE_WIDTH-1:0] feature_t;
    typedef feature_t [TN-1:0]        pixel_t;      // one memory word
    typedef pixel_t [WINDOW_TAPS-1:0] window_t;     // tap = row*3 + col, row 0 oldest
    typedef logic [ADDR_WIDTH-1:0]    addr_t;

    typedef enum logic {
        KERNEL_1X1,
        KERNEL_3X3
    } kernel_mode_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_SCAN,
        RD_FLUSH
    } read_state_e;

endpackage

`default_nettype wire

// ==== source/feature_window_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module feature_window_ctrl
    import feature_pkg::*;
#(
    parameter int FMAP_WIDTH  = 8,
    parameter int FMAP_HEIGHT = 6
)(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               wb_cyc,
    input  wire               wb_stb,
    input  wire               wb_we,
    input  wire addr_t        wb_adr,
    input  wire pixel_t       wb_dat_w,
    output pixel_t            wb_dat_r,
    output logic              wb_ack,
    input  wire               start,
    input  wire kernel_mode_e kernel_mode,
    input  wire addr_t        fmap_base,
    output logic              busy,
    output logic              window_valid,
    output window_t           window_data
);

    kernel_mode_e scan_mode;    // latched at start

    pixel_stream_if u_stream ();

    feature_mem u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .stream   (u_stream.mem_side)
    );

    read_sequencer #(
        .FMAP_WIDTH  (FMAP_WIDTH),
        .FMAP_HEIGHT (FMAP_HEIGHT)
    ) u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .kernel_mode (kernel_mode),
        .fmap_base   (fmap_base),
        .busy        (busy),
        .mode        (scan_mode),
        .stream      (u_stream.sequencer_side)
    );

    window_builder #(
        .FMAP_WIDTH (FMAP_WIDTH)
    ) u_builder (
        .clk          (clk),
        .rst_n        (rst_n),
        .mode         (scan_mode),
        .stream       (u_stream.builder_side),
        .window_valid (window_valid),
        .window_data  (window_data)
    );

endmodule

`default_nettype wire

// ==== source/line_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_buffer
    import feature_pkg::*;
#(
    parameter int LINE_LENGTH = 8
)(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         shift,
    input  wire pixel_t data_in,
    output pixel_t      data_out
);

    localparam int PTR_W = $clog2(LINE_LENGTH);

    pixel_t           line_mem [LINE_LENGTH];
    logic [PTR_W-1:0] wr_ptr;

    // slot about to be overwritten holds the oldest pixel
    assign data_out = line_mem[wr_ptr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wr_ptr <= '0;
        else if (shift)
        begin
            if (wr_ptr == PTR_W'(LINE_LENGTH - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (shift)
            line_mem[wr_ptr] <= data_in;
    end

endmodule

`default_nettype wire

// ==== source/pixel_stream_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface pixel_stream_if
    import feature_pkg::*;
();

    logic   rd_en;
    addr_t  rd_addr;
    logic   valid;      // pixel below is good this cycle
    pixel_t pixel;
    logic   col_last;   // aligned with valid
    logic   map_last;

    modport mem_side       (input rd_en, rd_addr, output valid, pixel);
    modport sequencer_side (output rd_en, rd_addr, col_last, map_last);
    modport builder_side   (input valid, pixel, col_last, map_last);

endinterface

`default_nettype wire

// ==== source/read_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_sequencer
    import feature_pkg::*;
#(
    parameter int FMAP_WIDTH  = 8,
    parameter int FMAP_HEIGHT = 6
)(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    input  wire kernel_mode_e      kernel_mode,
    input  wire addr_t             fmap_base,
    output logic                   busy,
    output kernel_mode_e           mode,
    pixel_stream_if.sequencer_side stream
);

    read_state_e state;
    addr_t       addr;
    logic        flush_cnt;
    logic        idle;
    logic        scanning;
    logic        cnt_col_last;
    logic        cnt_map_last;

    assign idle     = (state == RD_IDLE);
    assign scanning = (state == RD_SCAN);
    assign busy     = !idle;

    assign stream.rd_en   = scanning;
    assign stream.rd_addr = addr;

    scan_counter #(
        .FMAP_WIDTH  (FMAP_WIDTH),
        .FMAP_HEIGHT (FMAP_HEIGHT)
    ) u_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (idle),
        .step     (scanning),
        .col_last (cnt_col_last),
        .map_last (cnt_map_last)
    );

    ////////////////////////////////////////
    // scan fsm
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= RD_IDLE;
            mode      <= KERNEL_1X1;
            addr      <= '0;
            flush_cnt <= 1'b0;
        end
        else
        begin
            case (state)
                RD_IDLE:
                begin
                    flush_cnt <= 1'b0;
                    if (start)
                    begin
                        state <= RD_SCAN;
                        mode  <= kernel_mode;   // held for the whole scan
                        addr  <= fmap_base;
                    end
                end
                RD_SCAN:
                begin
                    addr <= addr + 1'b1;
                    if (cnt_map_last)
                        state <= RD_FLUSH;
                end
                RD_FLUSH:
                begin
                    flush_cnt <= 1'b1;
                    if (flush_cnt)
                        state <= RD_IDLE;   // two cycles for mem + window reg
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // flags follow the memory latency
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stream.col_last <= 1'b0;
            stream.map_last <= 1'b0;
        end
        else
        begin
            stream.col_last <= scanning && cnt_col_last;
            stream.map_last <= scanning && cnt_map_last;
        end
    end

endmodule

`default_nettype wire

// ==== source/scan_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module scan_counter #(
    parameter int FMAP_WIDTH  = 8,
    parameter int FMAP_HEIGHT = 6
)(
    input  wire  clk,
    input  wire  rst_n,
    input  wire  clear,
    input  wire  step,
    output logic col_last,
    output logic map_last
);

    localparam int COL_W = $clog2(FMAP_WIDTH);
    localparam int ROW_W = $clog2(FMAP_HEIGHT + 1);

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;

    assign col_last = (col == COL_W'(FMAP_WIDTH - 1));
    assign map_last = col_last && (row == ROW_W'(FMAP_HEIGHT - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            col <= '0;
            row <= '0;
        end
        else if (clear)
        begin
            col <= '0;
            row <= '0;
        end
        else if (step)
        begin
            if (map_last)
            begin
                col <= '0;
                row <= '0;
            end
            else if (col_last)
            begin
                col <= '0;          // wrap into next row
                row <= row + 1'b1;
            end
            else
                col <= col + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/window_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_builder
    import feature_pkg::*;
#(
    parameter int FMAP_WIDTH = 8
)(
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire kernel_mode_e    mode,
    pixel_stream_if.builder_side stream,
    output logic                 window_valid,
    output window_t              window_data
);

    localparam int COL_W = $clog2(FMAP_WIDTH);

    pixel_t                   row1_pix;     // one row back
    pixel_t                   row0_pix;     // two rows back
    pixel_t [KERNEL_SIZE-1:0] row_pix;
    window_t                  win_q;
    window_t                  win_next;
    logic [COL_W-1:0]         col;
    logic [1:0]               row;          // saturates at 2
    logic                     complete;

    line_buffer #(.LINE_LENGTH(FMAP_WIDTH)) u_line0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift    (stream.valid),
        .data_in  (stream.pixel),
        .data_out (row1_pix)
    );

    line_buffer #(.LINE_LENGTH(FMAP_WIDTH)) u_line1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .shift    (stream.valid),
        .data_in  (row1_pix),
        .data_out (row0_pix)
    );

    assign row_pix  = {stream.pixel, row1_pix, row0_pix};
    assign complete = (row == 2'd2) && (col >= COL_W'(KERNEL_SIZE - 1));

    ////////////////////////////////////////
    // 3x3 shift array
    ////////////////////////////////////////
    always_comb
    begin
        for (int r = 0; r < KERNEL_SIZE; r++)
        begin
            for (int c = 0; c < KERNEL_SIZE - 1; c++)
                win_next[r*KERNEL_SIZE + c] = win_q[r*KERNEL_SIZE + c + 1];
            win_next[r*KERNEL_SIZE + KERNEL_SIZE - 1] = row_pix[r];   // newest column
        end
    end

    always_ff @(posedge clk)
    begin
        if (stream.valid)
        begin
            win_q <= win_next;
            if (mode == KERNEL_1X1)
                window_data <= {{(WINDOW_TAPS-1)*$bits(pixel_t){1'b0}}, stream.pixel};
            else
                window_data <= win_next;
        end
    end

    // position of the incoming pixel
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            col <= '0;
            row <= '0;
        end
        else if (stream.valid)
        begin
            if (stream.map_last)
            begin
                col <= '0;
                row <= '0;
            end
            else if (stream.col_last)
            begin
                col <= '0;
                if (row != 2'd2)
                    row <= row + 2'd1;
            end
            else
                col <= col + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            window_valid <= 1'b0;
        else
            window_valid <= stream.valid && ((mode == KERNEL_1X1) || complete);
    end

endmodule

`default_nettype wire

// ==== testbench/feature_window_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module feature_window_checker
    import feature_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,
    input  wire          wb_we,
    input  wire          wb_ack,
    input  wire pixel_t  wb_dat_r,
    input  wire          window_valid,
    input  wire window_t window_data
);

    string   test_name    = "none";
    int      error_count  = 0;
    int      window_count = 0;
    int      ack_count    = 0;
    window_t win_q [$];     // expected windows, oldest first
    pixel_t  read_q [$];
    window_t exp_win;
    pixel_t  exp_pix;

    function automatic void expect_window(input window_t w);
        win_q.push_back(w);
    endfunction

    function automatic void expect_read(input pixel_t d);
        read_q.push_back(d);
    endfunction

    function automatic int pending_windows();
        return win_q.size();
    endfunction

    function automatic int pending_reads();
        return read_q.size();
    endfunction

    ////////////////////////////////////////
    // wishbone reads
    ////////////////////////////////////////
    always @(posedge clk)
    begin
        if (rst_n && wb_ack)
        begin
            ack_count++;
            if (!wb_we)
            begin
                if (read_q.size() == 0)
                begin
                    $display("%s: read ack with no read outstanding", test_name);
                    error_count++;
                end
                else
                begin
                    exp_pix = read_q.pop_front();
                    if (wb_dat_r !== exp_pix)
                    begin
                        $display("CHECK FAILED %s read data expected %h actual %h",
                                 test_name, exp_pix, wb_dat_r);
                        error_count++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // window stream
    ////////////////////////////////////////
    always @(posedge clk)
    begin
        if (rst_n && window_valid)
        begin
            window_count++;
            if (win_q.size() == 0)
            begin
                $display("%s: window arrived with nothing expected", test_name);
                error_count++;
            end
            else
            begin
                exp_win = win_q.pop_front();
                if (window_data !== exp_win)
                begin
                    $display("CHECK FAILED %s window expected %h actual %h",
                             test_name, exp_win, window_data);
                    error_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/feature_window_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module feature_window_props (
    input wire clk,
    input wire rst_n,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_ack,
    input wire busy,
    input wire window_valid
);

    int assert_errors = 0;

    ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else
        begin
            $error("wb_ack without an active cycle");
            assert_errors++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else
        begin
            $error("wb_ack high two cycles in a row");
            assert_errors++;
        end

    valid_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        window_valid |-> busy)
        else
        begin
            $error("window_valid while not busy");
            assert_errors++;
        end

    // holds while rst_n is low
    idle_in_reset: assert property (@(posedge clk) !rst_n |-> !busy)
        else
        begin
            $error("busy high during reset");
            assert_errors++;
        end

endmodule

bind feature_window_ctrl feature_window_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .busy         (busy),
    .window_valid (window_valid)
);

`default_nettype wire

// ==== testbench/tb_feature_window.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_feature_window
    import feature_pkg::*;
();

    localparam int FMAP_W     = 8;
    localparam int FMAP_H     = 6;
    localparam int MAP_PIXELS = FMAP_W * FMAP_H;
    localparam int WAIT_LIMIT = 200;    // cycles per wait

    logic         clk;
    logic         rst_n;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    addr_t        wb_adr;
    pixel_t       wb_dat_w;
    pixel_t       wb_dat_r;
    logic         wb_ack;
    logic         start;
    kernel_mode_e kernel_mode;
    addr_t        fmap_base;
    logic         busy;
    logic         window_valid;
    window_t      window_data;

    integer seed = 77;
    pixel_t mem_model [MEM_DEPTH];
    string  test_name = "none";
    int     tb_errors = 0;
    int     err_mark = 0;
    int     ack_mark;
    int     pass_count = 0;
    int     fail_count = 0;
    int     i;
    addr_t  addrs [16];
    addr_t  base;

    feature_window_ctrl #(
        .FMAP_WIDTH  (FMAP_W),
        .FMAP_HEIGHT (FMAP_H)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .start        (start),
        .kernel_mode  (kernel_mode),
        .fmap_base    (fmap_base),
        .busy         (busy),
        .window_valid (window_valid),
        .window_data  (window_data)
    );

    feature_window_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_we        (wb_we),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r),
        .window_valid (window_valid),
        .window_data  (window_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic abort_on_timeout(input string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic check_int(input string what, input int expected, input int actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED %s %s expected %0d actual %0d",
                     test_name, what, expected, actual);
            tb_errors++;
        end
    endtask

    // testbench, checker and bound assertion errors
    function automatic int total_errors();
        return tb_errors + u_checker.error_count + u_dut.u_props.assert_errors;
    endfunction

    task automatic begin_test(input string name);
        test_name           = name;
        u_checker.test_name = name;
    endtask

    task automatic end_test();
        int errs;
        errs     = total_errors() - err_mark;
        err_mark = total_errors();
        if (errs == 0)
        begin
            pass_count++;
            $display("test %s: pass", test_name);
        end
        else
        begin
            fail_count++;
            $display("test %s: fail with %0d errors", test_name, errs);
        end
    endtask

    // one classic cycle held until ack
    task automatic wb_cycle(input logic we, input addr_t adr, input pixel_t dat);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!wb_ack && n < WAIT_LIMIT);
        if (!wb_ack)
            abort_on_timeout("wb_ack");
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wb_write(input addr_t adr, input pixel_t dat);
        mem_model[adr] = dat;
        wb_cycle(1'b1, adr, dat);
    endtask

    task automatic wb_read(input addr_t adr);
        u_checker.expect_read(mem_model[adr]);
        wb_cycle(1'b0, adr, '0);
    endtask

    task automatic load_map(input addr_t map_base);
        for (int k = 0; k < MAP_PIXELS; k++)
            wb_write(addr_t'(map_base + k), pixel_t'($random(seed)));
    endtask

    task automatic wait_for_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            n++;
        end
        if (busy !== level)
            abort_on_timeout(level ? "busy to rise" : "busy to fall");
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            check_int("busy while idle", 0, busy);
            check_int("window_valid while idle", 0, window_valid);
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic void expect_scan(input kernel_mode_e mode, input addr_t map_base);
        window_t w;
        for (int y = 0; y < FMAP_H; y++)
        begin
            for (int x = 0; x < FMAP_W; x++)
            begin
                w = '0;
                if (mode == KERNEL_1X1)
                begin
                    w[0] = mem_model[addr_t'(map_base + y*FMAP_W + x)];
                    u_checker.expect_window(w);
                end
                else if (y >= 2 && x >= 2)
                begin
                    for (int r = 0; r < 3; r++)
                        for (int c = 0; c < 3; c++)
                            w[r*3 + c] = mem_model[addr_t'(map_base
                                         + (y - 2 + r)*FMAP_W + (x - 2 + c))];
                    u_checker.expect_window(w);
                end
            end
        end
    endfunction

    // poke gives a second start while the scan is running
    task automatic run_scan(input kernel_mode_e mode, input addr_t map_base, input bit poke);
        int mark;
        int expected;
        expected = (mode == KERNEL_3X3) ? (FMAP_W - 2)*(FMAP_H - 2) : MAP_PIXELS;
        mark     = u_checker.window_count;
        expect_scan(mode, map_base);
        @(posedge clk);
        start       <= 1'b1;
        kernel_mode <= mode;
        fmap_base   <= map_base;
        @(posedge clk);
        start <= 1'b0;
        wait_for_busy(1'b1);
        if (poke)
        begin
            @(posedge clk);
            start       <= 1'b1;
            kernel_mode <= (mode == KERNEL_3X3) ? KERNEL_1X1 : KERNEL_3X3;
            @(posedge clk);
            start <= 1'b0;
        end
        wait_for_busy(1'b0);
        check_int("window count", expected, u_checker.window_count - mark);
        check_int("windows missing at busy fall", 0, u_checker.pending_windows());
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////
    initial
    begin
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        start       = 1'b0;
        kernel_mode = KERNEL_1X1;
        fmap_base   = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        begin_test("reset_idle");
        check_int("busy after reset", 0, busy);
        check_int("window_valid after reset", 0, window_valid);
        check_int("wb_ack after reset", 0, wb_ack);
        check_idle(4);
        end_test();

        begin_test("wb_readback");
        ack_mark = u_checker.ack_count;
        for (i = 0; i < 16; i++)
        begin
            addrs[i] = addr_t'($random(seed));
            wb_write(addrs[i], pixel_t'($random(seed)));
        end
        for (i = 0; i < 16; i++)
            wb_read(addrs[i]);
        @(posedge clk);     // let the checker count the last ack
        check_int("ack count", 32, u_checker.ack_count - ack_mark);
        check_int("reads outstanding", 0, u_checker.pending_reads());
        end_test();

        begin_test("scan_3x3");
        base = addr_t'($unsigned($random(seed)) % (MEM_DEPTH - MAP_PIXELS + 1));
        load_map(base);
        check_idle(2);
        run_scan(KERNEL_3X3, base, 1'b0);
        check_idle(4);
        end_test();

        begin_test("scan_1x1");
        base = addr_t'($unsigned($random(seed)) % (MEM_DEPTH - MAP_PIXELS + 1));
        load_map(base);
        run_scan(KERNEL_1X1, base, 1'b0);
        check_idle(4);
        end_test();

        begin_test("back_to_back");
        base = addr_t'($unsigned($random(seed)) % (MEM_DEPTH - MAP_PIXELS + 1));
        load_map(base);
        for (i = 0; i < 4; i++)
            run_scan((i % 2) ? KERNEL_1X1 : KERNEL_3X3, base, i >= 2);
        check_idle(8);      // ignored start must not restart
        end_test();

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
